// File: vlog.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/unified_mem.sv
rtl/mem_arbiter.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/cpu5stage.sv
tests/cpu5stage_checker.sv
tests/cpu5stage_tb.sv

// File: Bender.yml
package:
  name: cpu5stage

export_include_dirs:
  - rtl

sources:
  - rtl/cpu_pkg.sv
  - rtl/unified_mem.sv
  - rtl/mem_arbiter.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/mem_wb_stage.sv
  - rtl/cpu5stage.sv
  - target: test
    files:
      - tests/cpu5stage_checker.sv
      - tests/cpu5stage_tb.sv

// File: tests/cpu5stage_tb.sv
`timescale 1ns/1ps

module cpu5stage_tb
	import cpu_pkg::*;
();

	localparam int NUM_ROWS = 4;
	localparam int PROG_WORDS = 24;
	localparam int MAX_RES = 5;
	localparam int TIMEOUT = 1000;
	localparam int DATA_BASE = 128;
	localparam int RES_BASE = 144;
	localparam int SCRATCH_BASE = 200;
	localparam logic [15:0] DATA_OFF = 16'd128;
	localparam logic [15:0] RES_OFF = 16'd144;

	logic clk, rst, run, host_req, host_we, halted;
	addr_t host_addr, pc;
	word_t host_wdata, host_rdata, cycles_consumed, exp_word;
	logic cmp_en, test_end, timed_out, report;
	logic [8*12-1:0] test_name;
	int error_total, tests_failed;
	int unsigned seed_ret;

	// the test table.
	logic [8*12-1:0] row_name [NUM_ROWS];
	word_t row_prog [NUM_ROWS][PROG_WORDS];
	word_t row_data [NUM_ROWS][2]; // words at DATA_BASE and DATA_BASE+1.
	word_t row_exp [NUM_ROWS][MAX_RES]; // words expected from RES_BASE up.
	int row_nres [NUM_ROWS];
	int fill;

	cpu5stage dut0 (
		.input_clk(clk), .rst(rst), .run(run), .host_req(host_req), .host_we(host_we),
		.host_addr(host_addr), .host_wdata(host_wdata), .host_rdata(host_rdata),
		.pc(pc), .halted(halted), .cycles_consumed(cycles_consumed)
	);

	cpu5stage_checker chk0 (
		.clk(clk), .rst(rst), .host_req(host_req), .host_we(host_we),
		.host_addr(host_addr), .host_rdata(host_rdata), .pc(pc), .halted(halted),
		.cycles_consumed(cycles_consumed), .cycle_limit(word_t'(TIMEOUT)),
		.cmp_en(cmp_en), .exp_word(exp_word), .test_name(test_name),
		.test_end(test_end), .timed_out(timed_out), .report(report),
		.error_total(error_total), .tests_failed(tests_failed)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////
	// program encoding
	////////////////////////////////////////

	function automatic word_t i_type(opcode_t op, reg_idx_t rd, reg_idx_t rs1,
		logic [15:0] imm);
		return {op, rd, rs1, imm};
	endfunction

	function automatic word_t r_type(opcode_t op, reg_idx_t rd, reg_idx_t rs1,
		reg_idx_t rs2);
		return {op, rd, rs1, rs2, 11'd0};
	endfunction

	task automatic emit(input int row, input word_t inst);
		row_prog[row][fill] = inst;
		fill++;
	endtask

	task automatic build_table();
		word_t d0, d1, x, sum;
		logic [15:0] imm;
		int n;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int a = 0; a < PROG_WORDS; a++) begin
				row_prog[r][a] = word_t'(a); // nop tagged with its own address.
			end
			row_data[r][0] = $urandom();
			row_data[r][1] = $urandom();
		end
		d0 = row_data[0][0];
		d1 = row_data[0][1];
		imm = 16'($urandom());
		row_name[0] = "alu_chain";
		fill = 0;
		emit(0, i_type(OP_LW, 1, 0, DATA_OFF));
		emit(0, i_type(OP_LW, 2, 0, DATA_OFF + 16'd1));
		emit(0, r_type(OP_ADD, 3, 1, 2));
		emit(0, r_type(OP_SUB, 4, 3, 1));
		emit(0, r_type(OP_AND, 5, 4, 3));
		emit(0, r_type(OP_OR, 6, 5, 2));
		emit(0, i_type(OP_ADDI, 7, 6, imm));
		for (int i = 0; i < 5; i++) begin
			emit(0, i_type(OP_SW, reg_idx_t'(3 + i), 0, RES_OFF + 16'(i)));
		end
		emit(0, i_type(OP_HLT, 0, 0, 16'd0));
		row_exp[0][0] = d0 + d1;
		row_exp[0][1] = row_exp[0][0] - d0;
		row_exp[0][2] = row_exp[0][1] & row_exp[0][0];
		row_exp[0][3] = row_exp[0][2] | d1;
		row_exp[0][4] = row_exp[0][3] + {{16{imm[15]}}, imm};
		row_nres[0] = 5;

		d0 = row_data[1][0];
		d1 = row_data[1][1];
		row_name[1] = "load_use";
		fill = 0;
		emit(1, i_type(OP_LW, 1, 0, DATA_OFF));
		emit(1, i_type(OP_LW, 2, 0, DATA_OFF + 16'd1));
		emit(1, r_type(OP_ADD, 3, 2, 1)); // r2 straight from the load.
		emit(1, i_type(OP_LW, 4, 0, DATA_OFF));
		emit(1, r_type(OP_ADD, 5, 4, 4));
		emit(1, i_type(OP_SW, 3, 0, RES_OFF));
		emit(1, i_type(OP_SW, 5, 0, RES_OFF + 16'd1));
		emit(1, i_type(OP_HLT, 0, 0, 16'd0));
		row_exp[1][0] = d0 + d1;
		row_exp[1][1] = d0 + d0;
		row_nres[1] = 2;

		x = $urandom() & 32'h3ffe;
		row_name[2] = "branches";
		fill = 0;
		emit(2, i_type(OP_ADDI, 1, 0, x[15:0]));
		emit(2, i_type(OP_ADDI, 2, 0, x[15:0]));
		emit(2, i_type(OP_ADDI, 3, 0, x[15:0] + 16'd1));
		emit(2, i_type(OP_ADDI, 10, 0, 16'h11));
		emit(2, i_type(OP_BEQ, 2, 1, 16'd2)); // 4: equal, on to 7.
		emit(2, i_type(OP_ADDI, 10, 0, 16'h66));
		emit(2, i_type(OP_ADDI, 10, 0, 16'h77));
		emit(2, i_type(OP_BNE, 2, 1, 16'd1)); // 7: equal, falls through.
		emit(2, i_type(OP_ADDI, 11, 0, 16'h22));
		emit(2, i_type(OP_BEQ, 3, 1, 16'd1)); // 9: differ, falls through.
		emit(2, i_type(OP_ADDI, 12, 0, 16'h33));
		emit(2, i_type(OP_BNE, 3, 1, 16'd1)); // 11: differ, on to 13.
		emit(2, i_type(OP_ADDI, 12, 0, 16'h99));
		for (int i = 0; i < 3; i++) begin
			emit(2, i_type(OP_SW, reg_idx_t'(10 + i), 0, RES_OFF + 16'(i)));
		end
		emit(2, i_type(OP_HLT, 0, 0, 16'd0));
		row_exp[2][0] = 32'h11; // taken beq skips both overwrites.
		row_exp[2][1] = 32'h22;
		row_exp[2][2] = 32'h33; // taken bne skips the 0x99.
		row_nres[2] = 3;

		n = 3 + int'($urandom() % 8);
		sum = 0;
		for (int k = 1; k <= n; k++) begin
			sum += word_t'(k);
		end
		row_name[3] = "count_loop";
		fill = 0;
		emit(3, i_type(OP_ADDI, 1, 0, 16'(n)));
		emit(3, i_type(OP_ADDI, 2, 0, 16'd0));
		emit(3, i_type(OP_ADDI, 0, 0, 16'h55));
		emit(3, r_type(OP_ADD, 2, 2, 1)); // 3: loop body.
		emit(3, i_type(OP_ADDI, 1, 1, 16'hffff));
		emit(3, i_type(OP_BNE, 0, 1, 16'd1)); // 5: to 7 while r1 is not zero.
		emit(3, i_type(OP_J, 0, 0, 16'd8));
		emit(3, i_type(OP_J, 0, 0, 16'd3));
		emit(3, i_type(OP_SW, 2, 0, RES_OFF));
		emit(3, i_type(OP_SW, 0, 0, RES_OFF + 16'd1));
		emit(3, r_type(OP_ADD, 3, 0, 0));
		emit(3, i_type(OP_SW, 3, 0, RES_OFF + 16'd2));
		emit(3, i_type(OP_HLT, 0, 0, 16'd0));
		row_exp[3][0] = sum;
		row_exp[3][1] = '0;
		row_exp[3][2] = '0;
		row_nres[3] = 3;
	endtask

	////////////////////////////////////////
	// host port and sequencing
	////////////////////////////////////////

	task automatic apply_reset();
		run = 1'b0;
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic host_write(input addr_t a, input word_t d);
		host_req = 1'b1;
		host_we = 1'b1;
		host_addr = a;
		host_wdata = d;
		@(negedge clk);
	endtask

	task automatic host_read(input addr_t a, input word_t e);
		host_req = 1'b1;
		host_we = 1'b0;
		host_addr = a;
		cmp_en = 1'b1;
		exp_word = e;
		@(negedge clk);
	endtask

	task automatic release_host();
		host_req = 1'b0;
		host_we = 1'b0;
		cmp_en = 1'b0;
	endtask

	task automatic close_test();
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	task automatic run_row(input int r);
		int waited;
		test_name = row_name[r];
		apply_reset();
		for (int a = 0; a < PROG_WORDS; a++) begin
			host_write(addr_t'(a), row_prog[r][a]);
		end
		host_write(addr_t'(DATA_BASE), row_data[r][0]);
		host_write(addr_t'(DATA_BASE + 1), row_data[r][1]);
		for (int i = 0; i < MAX_RES; i++) begin
			host_write(addr_t'(RES_BASE + i), ~word_t'(RES_BASE + i)); // stale marker.
		end
		release_host();
		run = 1'b1;
		waited = 0;
		while (!halted && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!halted) begin
			timed_out = 1'b1;
			@(negedge clk);
			timed_out = 1'b0;
		end
		repeat (4) @(negedge clk); // pc and counter should sit still here.
		run = 1'b0;
		for (int i = 0; i < row_nres[r]; i++) begin
			host_read(addr_t'(RES_BASE + i), row_exp[r][i]);
		end
		for (int a = 0; a < PROG_WORDS; a++) begin
			host_read(addr_t'(a), row_prog[r][a]);
		end
		release_host();
		close_test();
	endtask

	task automatic host_rw_test();
		word_t vals [16];
		test_name = "host_rw";
		apply_reset();
		for (int i = 0; i < 16; i++) begin
			vals[i] = $urandom();
			host_write(addr_t'(SCRATCH_BASE + i), vals[i]);
		end
		for (int i = 0; i < 16; i++) begin
			host_read(addr_t'(SCRATCH_BASE + i), vals[i]);
		end
		release_host();
		close_test();
	endtask

	initial begin
		rst = 1'b1;
		run = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		cmp_en = 1'b0;
		exp_word = '0;
		test_end = 1'b0;
		timed_out = 1'b0;
		report = 1'b0;
		test_name = '0;
		seed_ret = $urandom(32'had58_0eb9);
		build_table();
		@(negedge clk);
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		host_rw_test();
		report = 1'b1;
		@(negedge clk);
		report = 1'b0;
		@(negedge clk);
		if (error_total == 0 && tests_failed == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: tests/cpu5stage_checker.sv
`timescale 1ns/1ps

module cpu5stage_checker
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic host_req,
	input logic host_we,
	input addr_t host_addr,
	input word_t host_rdata,
	input addr_t pc,
	input logic halted,
	input word_t cycles_consumed,
	input word_t cycle_limit,
	input logic cmp_en,
	input word_t exp_word,
	input logic [8*12-1:0] test_name,
	input logic test_end,
	input logic timed_out,
	input logic report,
	output int error_total,
	output int tests_failed
);

	int test_errors;
	int tests_run;
	logic halted_q;
	addr_t pc_q;
	word_t cycles_q;

	initial begin
		error_total = 0;
		tests_failed = 0;
		test_errors = 0;
		tests_run = 0;
		halted_q = 1'b0;
	end

	always @(posedge clk) begin
		if (cmp_en && host_req && !host_we && (host_rdata !== exp_word)) begin
			$display("mismatch at %0t: host_rdata[%0d] got %h, expected %h",
				$time, host_addr, host_rdata, exp_word);
			test_errors++;
		end

		////////////////////////////////////////
		// frozen state after halt
		////////////////////////////////////////
		if (!rst && halted && halted_q) begin
			if (pc !== pc_q) begin
				$display("mismatch at %0t: pc got %h, expected %h", $time, pc, pc_q);
				test_errors++;
			end
			if (cycles_consumed !== cycles_q) begin
				$display("mismatch at %0t: cycles_consumed got %0d, expected %0d",
					$time, cycles_consumed, cycles_q);
				test_errors++;
			end
		end
		if (!rst && halted && !halted_q && (cycles_consumed > cycle_limit)) begin
			$display("%0s: cycles_consumed reached %0d, past the limit of %0d cycles",
				test_name, cycles_consumed, cycle_limit);
			test_errors++;
		end
		if (timed_out) begin
			$display("%0s: halted did not rise within %0d cycles", test_name, cycle_limit);
			test_errors++;
		end

		if (test_end) begin
			tests_run++;
			if (test_errors == 0) begin
				$display("test %0s: ok", test_name);
			end else begin
				tests_failed++;
				$display("test %0s: failed with %0d errors", test_name, test_errors);
			end
			error_total += test_errors;
			test_errors = 0;
		end
		if (report) begin
			$display("%0d tests run, %0d passed, %0d failed, %0d errors",
				tests_run, tests_run - tests_failed, tests_failed, error_total);
		end
		halted_q = halted && !rst;
		pc_q = pc;
		cycles_q = cycles_consumed;
	end

endmodule

// File: rtl/cpu5stage.sv
`timescale 1ns/1ps

module cpu5stage
	import cpu_pkg::*;
(
	input logic input_clk,
	input logic rst,
	input logic run,
	input logic host_req,
	input logic host_we,
	input addr_t host_addr,
	input word_t host_wdata,
	output word_t host_rdata,
	output addr_t pc,
	output logic halted,
	output word_t cycles_consumed
);

	logic frozen;
	logic stall, redirect, fetch_req, fetch_gnt, host_gnt, data_gnt;
	logic data_req, data_we, mem_we, wb_we, halt_seen;
	addr_t redirect_pc, id_pc, ex_pc, data_addr, mem_addr;
	word_t id_inst, ex_a, ex_b, ex_imm, mem_alu, mem_store;
	word_t data_wdata, wb_data, mem_wdata, mem_rdata;
	opcode_t ex_op, mem_op;
	reg_idx_t ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;

	// the host owns the memory this cycle, so the core sits still.
	assign frozen = halted || host_req;
	assign host_rdata = host_gnt ? mem_rdata : '0;

	fetch_stage u_fetch (
		.clk(input_clk), .rst(rst), .run(run), .halted(frozen), .stall(stall),
		.redirect(redirect), .redirect_pc(redirect_pc), .fetch_gnt(fetch_gnt),
		.fetch_rdata(mem_rdata), .fetch_req(fetch_req), .pc(pc), .id_pc(id_pc),
		.id_inst(id_inst)
	);

	decode_stage u_decode (
		.clk(input_clk), .rst(rst), .halted(frozen), .id_pc(id_pc), .id_inst(id_inst),
		.flush(redirect), .ex_rd(ex_rd), .ex_is_load(ex_op == OP_LW), .wb_we(wb_we),
		.wb_rd(wb_rd), .wb_data(wb_data), .stall(stall), .ex_op(ex_op), .ex_rs1(ex_rs1),
		.ex_rs2(ex_rs2), .ex_rd_out(ex_rd), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
		.ex_pc(ex_pc)
	);

	execute_stage u_execute (
		.clk(input_clk), .rst(rst), .halted(frozen), .ex_op(ex_op), .ex_rs1(ex_rs1),
		.ex_rs2(ex_rs2), .ex_rd(ex_rd), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
		.ex_pc(ex_pc), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
		.redirect(redirect), .redirect_pc(redirect_pc), .mem_op(mem_op), .mem_rd(mem_rd),
		.mem_alu(mem_alu), .mem_store(mem_store)
	);

	mem_wb_stage u_mem_wb (
		.clk(input_clk), .rst(rst), .halted(frozen), .mem_op(mem_op), .mem_rd(mem_rd),
		.mem_alu(mem_alu), .mem_store(mem_store), .data_rdata(mem_rdata),
		.data_req(data_req), .data_we(data_we), .data_addr(data_addr),
		.data_wdata(data_wdata), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
		.halt_seen(halt_seen)
	);

	mem_arbiter u_arb (
		.host_req(host_req), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .data_req(data_req), .data_we(data_we),
		.data_addr(data_addr), .data_wdata(data_wdata), .fetch_req(fetch_req),
		.fetch_addr(pc), .host_gnt(host_gnt), .data_gnt(data_gnt), .fetch_gnt(fetch_gnt),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	unified_mem u_mem (
		.clk(input_clk), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
	);

	always_ff @(posedge input_clk) begin
		if (rst) begin
			halted <= 1'b0;
			cycles_consumed <= '0;
		end else begin
			if (halt_seen) begin
				halted <= 1'b1; // sticky until reset.
			end
			if (run && !halted) begin
				cycles_consumed <= cycles_consumed + 32'd1;
			end
		end
	end

	// the memory stage never waits for the port.
	data_always_granted: assert property (
		@(posedge input_clk) disable iff (rst) data_req |-> data_gnt
	);

endmodule

// File: rtl/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic halted,
	input opcode_t mem_op,
	input reg_idx_t mem_rd,
	input word_t mem_alu,
	input word_t mem_store,
	input word_t data_rdata,
	output logic data_req,
	output logic data_we,
	output addr_t data_addr,
	output word_t data_wdata,
	output logic wb_we,
	output reg_idx_t wb_rd,
	output word_t wb_data,
	output logic halt_seen
);

	logic wb_is_load;
	word_t wb_load_q;
	word_t wb_alu_q;

	assign data_req = ((mem_op == OP_LW) || (mem_op == OP_SW)) && !halted;
	assign data_we = (mem_op == OP_SW) && !halted;
	assign data_addr = mem_alu[$bits(addr_t)-1:0];
	assign data_wdata = mem_store;

	////////////////////////////////////////
	// mem/wb register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_we <= 1'b0;
			wb_rd <= '0;
			wb_is_load <= 1'b0;
			halt_seen <= 1'b0;
		end else if (!halted) begin
			wb_we <= (mem_rd != '0); // non-writers carry rd 0.
			wb_rd <= mem_rd;
			wb_is_load <= (mem_op == OP_LW);
			halt_seen <= (mem_op == OP_HLT);
		end
	end

	always_ff @(posedge clk) begin
		if (!halted) begin
			wb_load_q <= data_rdata;
			wb_alu_q <= mem_alu;
		end
	end

	assign wb_data = wb_is_load ? wb_load_q : wb_alu_q;

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic halted,
	input opcode_t ex_op,
	input reg_idx_t ex_rs1,
	input reg_idx_t ex_rs2,
	input reg_idx_t ex_rd,
	input word_t ex_a,
	input word_t ex_b,
	input word_t ex_imm,
	input addr_t ex_pc,
	input logic wb_we,
	input reg_idx_t wb_rd,
	input word_t wb_data,
	output logic redirect,
	output addr_t redirect_pc,
	output opcode_t mem_op,
	output reg_idx_t mem_rd,
	output word_t mem_alu,
	output word_t mem_store
);

	word_t op_a;
	word_t op_b;
	word_t alu_res;
	logic taken;

	// ex/mem first, then mem/wb; a load result is only ready from mem/wb.
	function automatic word_t fwd(input reg_idx_t idx, input word_t reg_val);
		word_t val;
		if (idx == '0) begin
			val = reg_val;
		end else if ((mem_rd == idx) && (mem_op != OP_LW)) begin
			val = mem_alu;
		end else if (wb_we && (wb_rd == idx)) begin
			val = wb_data;
		end else begin
			val = reg_val;
		end
		return val;
	endfunction

	always_comb begin
		op_a = fwd(ex_rs1, ex_a);
		op_b = fwd(ex_rs2, ex_b);
		case (ex_op)
			OP_ADD: alu_res = op_a + op_b;
			OP_SUB: alu_res = op_a - op_b;
			OP_AND: alu_res = op_a & op_b;
			OP_OR: alu_res = op_a | op_b;
			OP_ADDI, OP_LW, OP_SW: alu_res = op_a + ex_imm;
			default: alu_res = '0;
		endcase
	end

	////////////////////////////////////////
	// branch and jump resolution
	////////////////////////////////////////

	always_comb begin
		taken = ((ex_op == OP_BEQ) && (op_a == op_b)) ||
			((ex_op == OP_BNE) && (op_a != op_b));
		redirect = taken || (ex_op == OP_J) || (ex_op == OP_HLT);
		if (ex_op == OP_J) begin
			redirect_pc = ex_imm[$bits(addr_t)-1:0];
		end else if (ex_op == OP_HLT) begin
			redirect_pc = ex_pc; // park fetch on the hlt, younger work squashed.
		end else begin
			redirect_pc = ex_pc + addr_t'(1) + ex_imm[$bits(addr_t)-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_op <= OP_NOP;
			mem_rd <= '0;
		end else if (!halted) begin
			mem_op <= ex_op;
			mem_rd <= ex_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (!halted) begin
			mem_alu <= alu_res;
			mem_store <= op_b;
		end
	end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module decode_stage
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic halted,
	input addr_t id_pc,
	input word_t id_inst,
	input logic flush,
	input reg_idx_t ex_rd,
	input logic ex_is_load,
	input logic wb_we,
	input reg_idx_t wb_rd,
	input word_t wb_data,
	output logic stall,
	output opcode_t ex_op,
	output reg_idx_t ex_rs1,
	output reg_idx_t ex_rs2,
	output reg_idx_t ex_rd_out,
	output word_t ex_a,
	output word_t ex_b,
	output word_t ex_imm,
	output addr_t ex_pc
);

	word_t regs [`CPU_NUM_REGS];
	opcode_t op;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t imm;
	word_t a_val;
	word_t b_val;

	function automatic word_t read_reg(input reg_idx_t idx);
		word_t val;
		if (idx == '0) begin
			val = '0;
		end else if (wb_we && (wb_rd == idx)) begin
			val = wb_data; // write-first.
		end else begin
			val = regs[idx];
		end
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (wb_we && !halted) begin
			regs[wb_rd] <= wb_data;
		end
	end

	////////////////////////////////////////
	// field decode
	////////////////////////////////////////

	always_comb begin
		if (id_inst[31:26] <= OP_HLT) begin
			op = opcode_t'(id_inst[31:26]);
		end else begin
			op = OP_NOP; // unknown opcodes do nothing.
		end
		imm = {{16{id_inst[15]}}, id_inst[15:0]};
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR: begin
				rd = id_inst[25:21];
				rs1 = id_inst[20:16];
				rs2 = id_inst[15:11];
			end
			OP_ADDI, OP_LW: begin
				rd = id_inst[25:21];
				rs1 = id_inst[20:16];
				rs2 = '0;
			end
			OP_SW, OP_BEQ, OP_BNE: begin
				rd = '0;
				rs1 = id_inst[20:16];
				rs2 = id_inst[25:21]; // second source sits in the rd field.
			end
			default: begin
				rd = '0;
				rs1 = '0;
				rs2 = '0;
			end
		endcase
		a_val = read_reg(rs1);
		b_val = read_reg(rs2);
	end

	// load in execute feeding the instruction here.
	assign stall = ex_is_load && (ex_rd != '0) && ((rs1 == ex_rd) || (rs2 == ex_rd));

	////////////////////////////////////////
	// id/ex register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_op <= OP_NOP;
			ex_rs1 <= '0;
			ex_rs2 <= '0;
			ex_rd_out <= '0;
		end else if (!halted) begin
			if (stall || flush) begin
				ex_op <= OP_NOP; // bubble.
				ex_rs1 <= '0;
				ex_rs2 <= '0;
				ex_rd_out <= '0;
			end else begin
				ex_op <= op;
				ex_rs1 <= rs1;
				ex_rs2 <= rs2;
				ex_rd_out <= rd;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!halted) begin
			ex_a <= a_val;
			ex_b <= b_val;
			ex_imm <= imm;
			ex_pc <= id_pc;
		end
	end

	no_r0_write: assert property (
		@(posedge clk) disable iff (rst) wb_we |-> (wb_rd != '0)
	);

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_stage
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic run,
	input logic halted,
	input logic stall,
	input logic redirect,
	input addr_t redirect_pc,
	input logic fetch_gnt,
	input word_t fetch_rdata,
	output logic fetch_req,
	output addr_t pc,
	output addr_t id_pc,
	output word_t id_inst
);

	word_t inst_q;
	logic id_valid; // if/id holds an instruction not yet taken by decode.

	assign fetch_req = run && !halted && !stall;

	// a held word that decode already took shows up as a nop.
	assign id_inst = id_valid ? inst_q : word_t'(0);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= addr_t'(`CPU_RESET_PC);
			id_valid <= 1'b0;
		end else if (!halted) begin
			if (redirect) begin
				pc <= redirect_pc;
				id_valid <= 1'b0; // squash the wrong path.
			end else if (stall) begin
				pc <= pc;
			end else if (fetch_gnt) begin
				pc <= pc + addr_t'(1);
				id_valid <= 1'b1;
			end else begin
				id_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!halted && !redirect && !stall && fetch_gnt) begin
			inst_q <= fetch_rdata;
			id_pc <= pc;
		end
	end

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
	import cpu_pkg::*;
(
	input logic host_req,
	input logic host_we,
	input addr_t host_addr,
	input word_t host_wdata,
	input logic data_req,
	input logic data_we,
	input addr_t data_addr,
	input word_t data_wdata,
	input logic fetch_req,
	input addr_t fetch_addr,
	output logic host_gnt,
	output logic data_gnt,
	output logic fetch_gnt,
	output logic mem_we,
	output addr_t mem_addr,
	output word_t mem_wdata
);

	grant_t winner;

	always_comb begin
		if (host_req) begin
			winner = GNT_HOST;
		end else if (data_req) begin
			winner = GNT_DATA;
		end else if (fetch_req) begin
			winner = GNT_FETCH;
		end else begin
			winner = GNT_NONE;
		end
	end

	assign host_gnt = (winner == GNT_HOST);
	assign data_gnt = (winner == GNT_DATA);
	assign fetch_gnt = (winner == GNT_FETCH);

	always_comb begin
		case (winner)
			GNT_HOST: begin
				mem_addr = host_addr;
				mem_wdata = host_wdata;
				mem_we = host_we;
			end
			GNT_DATA: begin
				mem_addr = data_addr;
				mem_wdata = data_wdata;
				mem_we = data_we;
			end
			default: begin
				mem_addr = fetch_addr; // fetch or idle, read only.
				mem_wdata = '0;
				mem_we = 1'b0;
			end
		endcase
	end

endmodule

// File: rtl/unified_mem.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module unified_mem
	import cpu_pkg::*;
(
	input logic clk,
	input logic we,
	input addr_t addr,
	input word_t wdata,
	output word_t rdata
);

	word_t mem [`CPU_MEM_DEPTH];

	assign rdata = mem[addr]; // combinational read.

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

endmodule

// File: rtl/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

	typedef logic [31:0] word_t; // data or instruction word.
	typedef logic [`CPU_ADDR_W-1:0] addr_t; // word address, pc counts words.
	typedef logic [4:0] reg_idx_t; // r0 reads zero.

	// instruction layout: op [31:26], rd [25:21], rs1 [20:16], rs2 [15:11], imm [15:0].
	// sw, beq and bne take their second source from the rd field.
	typedef enum logic [5:0] {
		OP_NOP = 6'd0,
		OP_ADD = 6'd1,
		OP_SUB = 6'd2,
		OP_AND = 6'd3,
		OP_OR = 6'd4,
		OP_ADDI = 6'd5,
		OP_LW = 6'd6,
		OP_SW = 6'd7,
		OP_BEQ = 6'd8,
		OP_BNE = 6'd9,
		OP_J = 6'd10,
		OP_HLT = 6'd11
	} opcode_t;

	typedef enum logic [1:0] {
		GNT_NONE,
		GNT_HOST,
		GNT_DATA,
		GNT_FETCH
	} grant_t;

endpackage

// File: rtl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

////////////////////////////////////////
// memory sizing
////////////////////////////////////////

`define CPU_MEM_DEPTH 256 // words in the shared memory.
`define CPU_ADDR_W 8 // word address bits.

////////////////////////////////////////
// core sizing
////////////////////////////////////////

`define CPU_NUM_REGS 32 // architectural registers.
`define CPU_RESET_PC 0 // first fetch address.

`endif
